// File: sources.f
+incdir+.
owt_frame_pkg.sv
owt_err_pkg.sv
owt_symbol_decoder.sv
owt_crc8.sv
owt_frame_rx.sv
owt_err_monitor.sv
owt_rx_top.sv
owt_rx_tb.sv

// File: owt_rx_tb.sv
// one-wire receiver testbench
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_rx_tb
    import owt_frame_pkg::*;
    import owt_err_pkg::*;
();

    localparam int CLK_NS   = 100;
    localparam int HB_NS    = `OWT_HALF_BIT_CYC * CLK_NS;
    // lead, sync, tail, cmd, long data, crc, tail, trailing idle
    localparam int FRAME_HB = 4 + 16 + 4 + 16 + 32 + 16 + 4 + 20;
    localparam int N_FRAMES = 18;
    localparam int WDOG_NS  = 2 * N_FRAMES * FRAME_HB * HB_NS;

    localparam int K_GOOD     = 0;
    localparam int K_BAD_CRC  = 1;
    localparam int K_BAD_TAIL = 2;
    localparam int K_BAD_PAIR = 3;

    localparam owt_err_cfg_t CFG_LEAKY = '{mode: 1'b0, add_sel: 2'd3, sub_sel: 2'd0};
    localparam owt_err_cfg_t CFG_DRAIN = '{mode: 1'b1, add_sel: 2'd0, sub_sel: 2'd3};

    // chk low leaves cmd and data unchecked
    typedef struct packed {
        logic        status;
        logic        chk;
        logic [7:0]  cmd;
        logic [15:0] data;
    } exp_t;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           owt_rx;
    owt_err_cfg_t   err_cfg;
    owt_rx_result_t result;
    logic           com_err;

    exp_t        exp_tab [64];
    int          n_exp   = 0;
    int          res_cnt = 0;
    int          err_cnt = 0;
    int          seed;
    int          model_cnt;
    logic        model_flag;
    logic [31:0] rnd;
    logic [6:0]  addr;
    logic [7:0]  cmd;
    int          k;

    owt_rx_top u_owt_rx_top (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_owt_rx  (owt_rx),
        .i_err_cfg (err_cfg),
        .o_result  (result),
        .o_com_err (com_err)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ============================================================
    // reference model
    // ============================================================
    function automatic logic [7:0] calc_crc(input logic [7:0] c, input logic [15:0] d,
                                            input logic long);
        logic [7:0]  crc;
        logic [23:0] stream;
        logic        fb;
        int          n;
        int          i;
        crc    = 8'h00;
        n      = long ? 24 : 16;
        stream = long ? {c, d} : {c, d[7:0], 8'h00};
        for (i = 0; i < n; i++) begin
            fb  = crc[7] ^ stream[23-i];
            crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return crc;
    endfunction

    function automatic int next_count(input int cnt, input logic status,
                                      input owt_err_cfg_t cfg);
        int add;
        int sub;
        add = 4 << cfg.add_sel;
        sub = 1 << cfg.sub_sel;
        if (status) begin
            return (cnt + add > `OWT_ERR_MAX) ? `OWT_ERR_MAX : cnt + add;
        end
        return (cnt > sub) ? cnt - sub : 0;
    endfunction

    function automatic logic flag_of(input int cnt, input owt_err_cfg_t cfg);
        return cfg.mode ? (cnt == 0) : (cnt >= (4 << cfg.add_sel));
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            model_cnt  <= `OWT_ERR_INIT;
            model_flag <= 1'b1;
        end else if (result.vld) begin
            model_cnt  <= next_count(model_cnt, exp_tab[res_cnt].status, err_cfg);
            model_flag <= flag_of(next_count(model_cnt, exp_tab[res_cnt].status, err_cfg),
                                  err_cfg);
        end
    end

    always @(posedge clk) begin
        if (result.vld) res_cnt <= res_cnt + 1;
    end

    // ============================================================
    // checks
    // ============================================================
    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !result.vld && com_err)
        else begin
            err_cnt++;
            $display("error at %0t ns: outputs not at reset values", $time);
        end

    a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
        result.vld |-> (res_cnt < n_exp) && (result.status == exp_tab[res_cnt].status)
            && (!exp_tab[res_cnt].chk || (result.cmd == exp_tab[res_cnt].cmd
            && result.data == exp_tab[res_cnt].data)))
        else begin
            err_cnt++;
            $display("error at %0t ns: result cmd %h data %h status %b not expected",
                     $time, $sampled(result.cmd), $sampled(result.data),
                     $sampled(result.status));
        end

    a_com_err: assert property (@(posedge clk) disable iff (!rst_n)
        result.vld |=> com_err == model_flag)
        else begin
            err_cnt++;
            $display("error at %0t ns: com_err %b, model %b", $time, com_err, model_flag);
        end

    // ============================================================
    // line driver
    // ============================================================
    task automatic drive_half(input logic lvl);
        @(posedge clk);
        owt_rx <= lvl;
        repeat (`OWT_HALF_BIT_CYC - 1) @(posedge clk);
    endtask

    // zero is high then low
    task automatic drive_bit(input logic b);
        drive_half(!b);
        drive_half(b);
    endtask

    task automatic drive_tail(input logic [3:0] pat);
        int i;
        for (i = 3; i >= 0; i--) drive_half(pat[i]);
    endtask

    task automatic send_frame(input logic [7:0] c, input logic [15:0] d_in, input int kind);
        logic        long;
        logic [15:0] d;
        logic [7:0]  crc;
        exp_t        e;
        int          i;
        long = !c[7] && (c[6:0] == `OWT_ADC_ADDR);
        d    = long ? d_in : {8'h00, d_in[7:0]};
        crc  = calc_crc(c, d, long);
        if (kind == K_BAD_CRC) crc = crc ^ 8'h5A;
        e.status = (kind != K_GOOD);
        e.chk    = (kind != K_BAD_PAIR);
        e.cmd    = c;
        e.data   = d;
        exp_tab[n_exp] = e;
        n_exp++;
        repeat (4) drive_half(1'b1);
        repeat (`OWT_SYNC_BIT_NUM) drive_bit(1'b0);
        drive_tail(`OWT_TAIL_PATTERN);
        if (kind == K_BAD_PAIR) begin
            // frame cut after a flat pair in the command
            for (i = 7; i >= 4; i--) drive_bit(c[i]);
            drive_half(1'b1);
            drive_half(1'b1);
        end else begin
            for (i = 7; i >= 0; i--) drive_bit(c[i]);
            for (i = (long ? 15 : 7); i >= 0; i--) drive_bit(d[i]);
            for (i = 7; i >= 0; i--) drive_bit(crc[i]);
            drive_tail((kind == K_BAD_TAIL) ? 4'b1000 : `OWT_TAIL_PATTERN);
        end
        repeat (20) drive_half(1'b1);
    endtask

    task automatic wait_results();
        while (res_cnt < n_exp) @(posedge clk);
    endtask

    task automatic apply_reset(input owt_err_cfg_t cfg);
        @(posedge clk);
        rst_n   <= 1'b0;
        err_cfg <= cfg;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    initial begin
        #(WDOG_NS);
        $display("timeout: the frames did not finish in the expected run time");
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        owt_rx  = 1'b1;
        err_cfg = CFG_LEAKY;
        seed    = 50550;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // writes and short reads
        for (k = 0; k < 6; k++) begin
            rnd  = $random(seed);
            addr = rnd[6:0];
            rnd  = $random(seed);
            if (k % 2 == 0) cmd = {1'b1, addr};
            else cmd = {1'b0, (addr == `OWT_ADC_ADDR) ? ~addr : addr};
            send_frame(cmd, {8'h00, rnd[7:0]}, K_GOOD);
            wait_results();
        end

        // adc reads
        for (k = 0; k < 4; k++) begin
            rnd = $random(seed);
            send_frame({1'b0, `OWT_ADC_ADDR}, rnd[15:0], K_GOOD);
            wait_results();
        end

        // broken frames
        rnd = $random(seed);
        send_frame(8'hA5, {8'h00, rnd[7:0]}, K_BAD_CRC);
        wait_results();
        send_frame(8'h83, {8'h00, rnd[15:8]}, K_BAD_TAIL);
        wait_results();
        send_frame(8'h5C, 16'h0000, K_BAD_PAIR);
        wait_results();

        // drain to zero in mode 1
        apply_reset(CFG_DRAIN);
        repeat (4) @(posedge clk);
        for (k = 0; k < 5; k++) begin
            rnd = $random(seed);
            send_frame({1'b1, rnd[14:8]}, {8'h00, rnd[7:0]}, K_GOOD);
            wait_results();
        end
        repeat (4) @(posedge clk);

        if (res_cnt != n_exp) begin
            err_cnt++;
            $display("the DUT gave %0d results for %0d frames", res_cnt, n_exp);
        end
        $display("results %0d of %0d expected, errors %0d", res_cnt, n_exp, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: owt_rx_top.sv
// one-wire receiver top
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_rx_top
    import owt_frame_pkg::*;
    import owt_err_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_owt_rx,
    input  wire owt_err_cfg_t i_err_cfg,
    output owt_rx_result_t    o_result,
    output logic              o_com_err
);

    owt_sample_t                 sample;
    owt_sym_t                    sym;
    logic                        hunt;
    logic                        pair_en;
    logic                        crc_vld;
    logic                        crc_bit;
    logic                        crc_start;
    logic [`OWT_CRC_BIT_NUM-1:0] crc;

    owt_symbol_decoder u_symbol_decoder (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_owt_rx  (i_owt_rx),
        .i_hunt    (hunt),
        .i_pair_en (pair_en),
        .o_sample  (sample),
        .o_sym     (sym)
    );

    owt_frame_rx u_frame_rx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sample    (sample),
        .i_sym       (sym),
        .i_crc       (crc),
        .o_hunt      (hunt),
        .o_pair_en   (pair_en),
        .o_crc_vld   (crc_vld),
        .o_crc_bit   (crc_bit),
        .o_crc_start (crc_start),
        .o_result    (o_result)
    );

    owt_crc8 u_crc8 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bit_vld (crc_vld),
        .i_bit     (crc_bit),
        .i_start   (crc_start),
        .o_crc     (crc)
    );

    owt_err_monitor u_err_monitor (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_result  (o_result),
        .i_cfg     (i_err_cfg),
        .o_com_err (o_com_err)
    );

endmodule

`default_nettype wire

// File: owt_err_monitor.sv
// communication error monitor
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_err_monitor
    import owt_frame_pkg::*;
    import owt_err_pkg::*;
(
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire owt_rx_result_t i_result,
    input  wire owt_err_cfg_t   i_cfg,
    output logic                o_com_err
);

    localparam int CNT_W = $clog2(`OWT_ERR_MAX + 1);

    logic [CNT_W-1:0] err_cnt;
    logic [CNT_W-1:0] cnt_nxt;
    logic [CNT_W-1:0] add_step;
    logic [CNT_W-1:0] sub_step;
    logic [CNT_W:0]   sum;

    assign add_step = CNT_W'(OWT_ERR_ADD_STEP[i_cfg.add_sel]);
    assign sub_step = CNT_W'(OWT_ERR_SUB_STEP[i_cfg.sub_sel]);
    assign sum      = {1'b0, err_cnt} + {1'b0, add_step};

    // leaky count, saturate high and floor at zero
    always_comb begin
        cnt_nxt = err_cnt;
        if (i_result.vld) begin
            if (i_result.status) begin
                cnt_nxt = (sum >= (CNT_W + 1)'(`OWT_ERR_MAX)) ? CNT_W'(`OWT_ERR_MAX)
                                                             : sum[CNT_W-1:0];
            end else begin
                cnt_nxt = (err_cnt <= sub_step) ? '0 : (err_cnt - sub_step);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_cnt   <= CNT_W'(`OWT_ERR_INIT);
            o_com_err <= 1'b1;
        end else begin
            err_cnt   <= cnt_nxt;
            o_com_err <= i_cfg.mode ? (cnt_nxt == '0) : (cnt_nxt >= add_step);
        end
    end

    a_cnt_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        err_cnt <= CNT_W'(`OWT_ERR_MAX))
        else $error("error count above limit");

endmodule

`default_nettype wire

// File: owt_frame_rx.sv
// one-wire frame receiver
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_frame_rx
    import owt_frame_pkg::*;
(
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire owt_sample_t            i_sample,
    input  wire owt_sym_t               i_sym,
    input  wire [`OWT_CRC_BIT_NUM-1:0]  i_crc,
    output logic                        o_hunt,
    output logic                        o_pair_en,
    output logic                        o_crc_vld,
    output logic                        o_crc_bit,
    output logic                        o_crc_start,
    output owt_rx_result_t              o_result
);

    localparam int CW = `OWT_CNT_W;

    owt_state_e                   state;
    owt_state_e                   nxt;
    logic [CW-1:0]                bit_cnt;
    logic [CW-1:0]                last_idx;
    logic                         tail_st;
    logic                         data_st;
    logic                         step;
    logic                         last;
    logic                         noise;
    logic                         fire;
    logic                         status;
    logic                         adc_rd;
    logic [`OWT_TAIL_BIT_NUM-1:0] tail_sr;
    logic [`OWT_TAIL_BIT_NUM-1:0] tail_cur;
    logic [`OWT_CMD_BIT_NUM-1:0]  cmd_sr;
    logic [`OWT_CMD_BIT_NUM-1:0]  cmd_cur;
    logic [`OWT_ADCD_BIT_NUM-1:0] data_sr;
    logic [`OWT_CRC_BIT_NUM-1:0]  crc_sr;
    logic [`OWT_CRC_BIT_NUM-1:0]  crc_lock;

    assign tail_st  = (state == ST_SYNC_TAIL) || (state == ST_END_TAIL);
    assign data_st  = (state == ST_ADC_DATA) || (state == ST_NML_DATA);
    assign tail_cur = {tail_sr[`OWT_TAIL_BIT_NUM-2:0], i_sample.level};
    assign cmd_cur  = {cmd_sr[`OWT_CMD_BIT_NUM-2:0], i_sym.val};
    // top bit low means read
    assign adc_rd   = !cmd_cur[`OWT_CMD_BIT_NUM-1]
                   && (cmd_cur[`OWT_CMD_BIT_NUM-2:0] == `OWT_ADC_ADDR);

    // tails count raw samples, everything else counts bits
    assign step = tail_st ? i_sample.vld : i_sym.vld;
    assign last = step && (bit_cnt == last_idx);

    always_comb begin
        case (state)
            ST_SYNC_HEAD: last_idx = CW'(`OWT_SYNC_BIT_NUM - 2);
            ST_SYNC_TAIL: last_idx = CW'(`OWT_TAIL_BIT_NUM - 1);
            ST_END_TAIL:  last_idx = CW'(`OWT_TAIL_BIT_NUM - 1);
            ST_CMD:       last_idx = CW'(`OWT_CMD_BIT_NUM - 1);
            ST_ADC_DATA:  last_idx = CW'(`OWT_ADCD_BIT_NUM - 1);
            ST_NML_DATA:  last_idx = CW'(`OWT_DATA_BIT_NUM - 1);
            default:      last_idx = CW'(`OWT_CRC_BIT_NUM - 1);
        endcase
    end

    // ============================================================
    // frame fsm
    // ============================================================
    always_comb begin
        nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_sym.vld) nxt = ST_SYNC_HEAD;
            end
            ST_SYNC_HEAD: begin
                if (i_sym.invld || (i_sym.vld && i_sym.val)) nxt = ST_IDLE;
                else if (last) nxt = ST_SYNC_TAIL;
            end
            ST_SYNC_TAIL: begin
                if (last) nxt = (tail_cur == `OWT_TAIL_PATTERN) ? ST_CMD : ST_IDLE;
            end
            ST_CMD: begin
                if (i_sym.invld) nxt = ST_IDLE;
                else if (last) nxt = adc_rd ? ST_ADC_DATA : ST_NML_DATA;
            end
            ST_ADC_DATA, ST_NML_DATA: begin
                if (i_sym.invld) nxt = ST_IDLE;
                else if (last) nxt = ST_CRC;
            end
            ST_CRC: begin
                if (i_sym.invld) nxt = ST_IDLE;
                else if (last) nxt = ST_END_TAIL;
            end
            default: begin
                if (last) nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            state <= nxt;
            if (nxt != state) begin
                bit_cnt <= '0;
            end else if (step) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // field shift registers
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tail_sr  <= '0;
            cmd_sr   <= '0;
            data_sr  <= '0;
            crc_sr   <= '0;
            crc_lock <= '0;
        end else begin
            if (tail_st && i_sample.vld) tail_sr <= tail_cur;
            if (state == ST_CMD && i_sym.vld) cmd_sr <= cmd_cur;
            // cleared during cmd so short data leaves the upper byte zero
            if (state == ST_CMD) begin
                data_sr <= '0;
            end else if (data_st && i_sym.vld) begin
                data_sr <= {data_sr[`OWT_ADCD_BIT_NUM-2:0], i_sym.val};
            end
            if (state == ST_CRC && i_sym.vld) crc_sr <= {crc_sr[`OWT_CRC_BIT_NUM-2:0], i_sym.val};
            // checker has taken the last data bit by now
            if (state == ST_CRC && bit_cnt == '0) crc_lock <= i_crc;
        end
    end

    // one in the sync head is noise, no result
    assign noise  = (state == ST_SYNC_HEAD) && i_sym.vld && i_sym.val;
    assign fire   = (state != ST_IDLE) && (nxt == ST_IDLE) && !noise;
    assign status = (state != ST_END_TAIL) || (tail_cur != `OWT_TAIL_PATTERN)
                 || (crc_lock != crc_sr);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else begin
            o_result.vld <= fire;
            if (fire) begin
                o_result.status <= status;
                o_result.cmd    <= cmd_sr;
                o_result.data   <= data_sr;
            end
        end
    end

    assign o_hunt      = (state == ST_IDLE);
    assign o_pair_en   = !tail_st;
    assign o_crc_vld   = i_sym.vld && ((state == ST_CMD) || data_st);
    assign o_crc_bit   = i_sym.val;
    assign o_crc_start = i_sym.vld && (state == ST_CMD) && (bit_cnt == '0);

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state inside {ST_IDLE, ST_SYNC_HEAD, ST_SYNC_TAIL, ST_CMD,
                      ST_ADC_DATA, ST_NML_DATA, ST_CRC, ST_END_TAIL})
        else $error("frame fsm in illegal state");

    a_result_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_result.vld |=> !o_result.vld)
        else $error("result valid held for two cycles");

endmodule

`default_nettype wire

// File: owt_crc8.sv
// serial crc-8 checker
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_crc8 (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_bit_vld,
    input  wire                         i_bit,
    input  wire                         i_start,
    output logic [`OWT_CRC_BIT_NUM-1:0] o_crc
);

    logic [`OWT_CRC_BIT_NUM-1:0] crc_base;
    logic [`OWT_CRC_BIT_NUM-1:0] crc_nxt;
    logic                        fb;

    // msb first, start bit restarts from zero
    always_comb begin
        crc_base = i_start ? '0 : o_crc;
        fb       = crc_base[`OWT_CRC_BIT_NUM-1] ^ i_bit;
        crc_nxt  = {crc_base[`OWT_CRC_BIT_NUM-2:0], 1'b0} ^ ({`OWT_CRC_BIT_NUM{fb}} & `OWT_CRC_POLY);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_bit_vld) begin
            o_crc <= crc_nxt;
        end
    end

endmodule

`default_nettype wire

// File: owt_symbol_decoder.sv
// manchester symbol decoder
`timescale 1ns/1ps
`default_nettype none
`include "owt_params.svh"

module owt_symbol_decoder
    import owt_frame_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_owt_rx,
    input  wire         i_hunt,
    input  wire         i_pair_en,
    output owt_sample_t o_sample,
    output owt_sym_t    o_sym
);

    localparam int CYC_W = $clog2(`OWT_HALF_BIT_CYC);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             line_edge;
    logic [CYC_W-1:0] cyc_cnt;
    logic             samp_hit;
    logic             pair_phase;
    logic             prev_lvl;

    // line idles high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_owt_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign line_edge = rx_sync ^ rx_prev;
    assign samp_hit  = !line_edge && (cyc_cnt == CYC_W'(`OWT_HALF_BIT_CYC / 2));

    // restart on every edge, free-run through flat stretches
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cyc_cnt <= '0;
        end else if (line_edge || cyc_cnt == CYC_W'(`OWT_HALF_BIT_CYC - 1)) begin
            cyc_cnt <= '0;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sample <= '0;
        end else begin
            o_sample.vld <= samp_hit;
            if (samp_hit) begin
                o_sample.level <= rx_sync;
            end
        end
    end

    // ============================================================
    // pairing
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pair_phase <= 1'b0;
            prev_lvl   <= 1'b1;
            o_sym      <= '0;
        end else begin
            o_sym <= '0;
            if (o_sample.vld) begin
                prev_lvl <= o_sample.level;
            end
            if (i_hunt) begin
                // falling half-bit reports a zero, next sample opens a pair
                pair_phase <= 1'b0;
                o_sym.vld  <= o_sample.vld && prev_lvl && !o_sample.level;
            end else if (!i_pair_en) begin
                pair_phase <= 1'b0;
            end else if (o_sample.vld) begin
                pair_phase <= !pair_phase;
                if (pair_phase) begin
                    o_sym.vld   <= prev_lvl ^ o_sample.level;
                    o_sym.val   <= o_sample.level;
                    o_sym.invld <= !(prev_lvl ^ o_sample.level);
                end
            end
        end
    end

    a_sym_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_sym.vld && o_sym.invld))
        else $error("symbol flagged valid and invalid together");

endmodule

`default_nettype wire

// File: owt_err_pkg.sv
// error monitor types
`default_nettype none

package owt_err_pkg;

    // mode 0: flag while count >= add step; mode 1: flag at zero
    typedef struct packed {
        logic       mode;
        logic [1:0] add_sel;
        logic [1:0] sub_sel;
    } owt_err_cfg_t;

    // ============================================================
    // step tables, indexed by the select fields
    // ============================================================
    localparam int unsigned OWT_ERR_ADD_STEP [4] = '{4, 8, 16, 32};
    localparam int unsigned OWT_ERR_SUB_STEP [4] = '{1, 2, 4, 8};

endpackage

`default_nettype wire

// File: owt_frame_pkg.sv
// frame receive types
`default_nettype none
`include "owt_params.svh"

package owt_frame_pkg;

    // receiver states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_SYNC_HEAD = 3'd1,
        ST_SYNC_TAIL = 3'd2,
        ST_CMD       = 3'd3,
        ST_ADC_DATA  = 3'd4,
        ST_NML_DATA  = 3'd5,
        ST_CRC       = 3'd6,
        ST_END_TAIL  = 3'd7
    } owt_state_e;

    // one half-bit sample of the line
    typedef struct packed {
        logic vld;
        logic level;
    } owt_sample_t;

    // one manchester event; vld and invld never together
    typedef struct packed {
        logic vld;
        logic val;
        logic invld;
    } owt_sym_t;

    // finished frame, 8-bit data sits in the low byte
    typedef struct packed {
        logic                          vld;
        logic                          status;
        logic [`OWT_CMD_BIT_NUM-1:0]   cmd;
        logic [`OWT_ADCD_BIT_NUM-1:0]  data;
    } owt_rx_result_t;

endpackage

`default_nettype wire

// File: owt_params.svh
// one-wire receiver parameters
`ifndef OWT_PARAMS_SVH
`define OWT_PARAMS_SVH

// ============================================================
// line timing
// ============================================================
// clock cycles per manchester half-bit
`define OWT_HALF_BIT_CYC    8

// ============================================================
// frame fields
// ============================================================
`define OWT_SYNC_BIT_NUM    8
// raw half-bit samples per tail
`define OWT_TAIL_BIT_NUM    4
// high, high, low, low
`define OWT_TAIL_PATTERN    4'b1100
`define OWT_CMD_BIT_NUM     8
`define OWT_DATA_BIT_NUM    8
`define OWT_ADCD_BIT_NUM    16
`define OWT_CRC_BIT_NUM     8
// read from this address carries the long data field
`define OWT_ADC_ADDR        7'h1F
`define OWT_CRC_POLY        8'h07

// ============================================================
// counters
// ============================================================
`define OWT_ERR_INIT        32
`define OWT_ERR_MAX         512
`define OWT_CNT_W           5

`endif
